/* project.f */
+incdir+include
rtl/msx_bus_pkg.sv
rtl/msx_dev_pkg.sv
rtl/mapper_ram_regs.sv
rtl/bank_mapper.sv
rtl/scc_wave.sv
rtl/devices.sv
sim/tb_devices.sv

/* run.sh */
#!/bin/sh
# Build and run the devices testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_devices -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_devices > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* sim/tb_devices.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_devices_macros.svh"

module tb_devices;

    logic                  clk;
    logic                  rst;
    msx_bus_pkg::addr_t    addr;
    msx_bus_pkg::data_t    wdata;
    logic                  rd;
    logic                  wr;
    logic                  iorq;
    logic                  mreq;
    logic                  ram_slot_sel;
    logic                  cart_slot_sel;
    logic                  ram_enable;
    logic                  bank_enable;
    logic                  scc_enable;
    msx_bus_pkg::sample_t  sound;
    msx_bus_pkg::data_t    data;
    logic                  output_rq;
    msx_dev_pkg::segment_t data_to_mapper;

    msx_bus_pkg::data_t    seen_data;       // Outputs captured mid-cycle
    logic                  seen_rq;
    msx_dev_pkg::segment_t seen_map;
    msx_bus_pkg::data_t    stored [32];     // Expected readback values
    int                    seed = 32'h2611_bdb6;

    devices i_devices (
        .clk            (clk),
        .rst            (rst),
        .addr           (addr),
        .wdata          (wdata),
        .rd             (rd),
        .wr             (wr),
        .iorq           (iorq),
        .mreq           (mreq),
        .ram_slot_sel   (ram_slot_sel),
        .cart_slot_sel  (cart_slot_sel),
        .ram_enable     (ram_enable),
        .bank_enable    (bank_enable),
        .scc_enable     (scc_enable),
        .sound          (sound),
        .data           (data),
        .output_rq      (output_rq),
        .data_to_mapper (data_to_mapper)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // A device may only answer a read strobe
    rq_only_on_read: assert property (@(posedge clk) disable iff (rst) output_rq |-> rd)
        else begin
            $display("output_rq was raised without a read strobe");
            stop_run();
        end

    task automatic stop_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_sample(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic msx_bus_pkg::data_t rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic msx_bus_pkg::data_t port_of(input int n);
        return `MAPPER_PORT_BASE + 8'(n);
    endfunction

    // One strobe cycle, outputs sampled on the falling edge
    task automatic bus_cycle(input msx_bus_pkg::addr_t a, input msx_bus_pkg::data_t d,
                             input logic do_wr, input logic io, input logic ram,
                             input logic cart);
        @(posedge clk);
        addr          <= a;
        wdata         <= d;
        wr            <= do_wr;
        rd            <= ~do_wr;
        iorq          <= io;
        mreq          <= ~io;
        ram_slot_sel  <= ram;
        cart_slot_sel <= cart;
        @(negedge clk);
        seen_data = data;
        seen_rq   = output_rq;
        seen_map  = data_to_mapper;
        @(posedge clk);
        wr            <= 1'b0;
        rd            <= 1'b0;
        iorq          <= 1'b0;
        mreq          <= 1'b0;
        ram_slot_sel  <= 1'b0;
        cart_slot_sel <= 1'b0;
    endtask

    task automatic io_write(input msx_bus_pkg::data_t port, input msx_bus_pkg::data_t value);
        bus_cycle({8'h00, port}, value, 1'b1, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic io_read(input msx_bus_pkg::data_t port);
        bus_cycle({8'h00, port}, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0);
    endtask

    // Memory writes always go to the cartridge slot
    task automatic mem_write(input msx_bus_pkg::addr_t a, input msx_bus_pkg::data_t value);
        bus_cycle(a, value, 1'b1, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic mem_read(input msx_bus_pkg::addr_t a, input logic ram, input logic cart);
        bus_cycle(a, 8'h00, 1'b0, 1'b0, ram, cart);
    endtask

    task automatic wait_sound(input msx_bus_pkg::sample_t target, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (sound !== target) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("Timeout while waiting for %s", what);
                stop_run();
            end
        end
    endtask

    initial begin
        msx_bus_pkg::data_t value;
        logic signed [7:0]  level_byte;
        logic signed [15:0] exp_sound;

        rst           <= 1'b1;
        addr          <= '0;
        wdata         <= '0;
        rd            <= 1'b0;
        wr            <= 1'b0;
        iorq          <= 1'b0;
        mreq          <= 1'b0;
        ram_slot_sel  <= 1'b0;
        cart_slot_sel <= 1'b0;
        ram_enable    <= 1'b1;
        bank_enable   <= 1'b1;
        scc_enable    <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_bit("output_rq", output_rq, 1'b0);
        check_byte("data", data, 8'hFF);
        check_sample("sound", sound, 16'h0000);
        for (int n = 0; n < 4; n++) begin
            io_read(port_of(n));
            check_byte("data", seen_data, 8'hF8 | 8'(3 - n));  // Reset segments 3..0
            check_bit("output_rq", seen_rq, 1'b1);
        end

        for (int n = 0; n < 4; n++) begin
            value = rand_byte();
            if (value[2:0] == 3'(3 - n)) begin
                value = value ^ 8'h04;                          // Differ from the reset segment
            end
            io_write(port_of(n), value);
            stored[n] = value | 8'hF8;                          // Only 3 bits kept
        end
        for (int n = 0; n < 4; n++) begin
            io_read(port_of(n));
            check_byte("data", seen_data, stored[n]);
            check_bit("output_rq", seen_rq, 1'b1);
            mem_read({2'(n), 14'h0123}, 1'b1, 1'b0);
            check_byte("data_to_mapper", seen_map, stored[n]);
        end
        @(posedge clk);
        ram_enable <= 1'b0;
        io_read(port_of(1));
        check_byte("data", seen_data, 8'hFF);
        check_bit("output_rq", seen_rq, 1'b0);
        @(posedge clk);
        ram_enable <= 1'b1;

        for (int n = 0; n < 4; n++) begin
            stored[n] = rand_byte();
            mem_write(`BANK_REG_BASE + 16'(n) * 16'h0800, stored[n]);
        end
        for (int n = 0; n < 4; n++) begin
            mem_read(16'h4000 + 16'(n) * 16'h2000, 1'b0, 1'b1);
            check_byte("data_to_mapper", seen_map, stored[n]);
        end
        mem_read(16'hC000, 1'b0, 1'b1);
        check_byte("data_to_mapper", seen_map, 8'hFF);
        mem_read(16'h4000, 1'b0, 1'b0);                         // No slot selected
        check_byte("data_to_mapper", seen_map, 8'hFF);

        for (int i = 0; i < 32; i++) begin
            stored[i] = rand_byte();
            mem_write(16'h9800 + 16'(i), stored[i]);
        end
        for (int i = 0; i < 32; i++) begin
            mem_read(16'h9800 + 16'(i), 1'b0, 1'b1);
            check_byte("data", seen_data, stored[i]);
            check_bit("output_rq", seen_rq, 1'b1);
        end
        @(posedge clk);
        scc_enable <= 1'b0;
        mem_read(16'h9805, 1'b0, 1'b1);
        check_byte("data", seen_data, 8'hFF);
        check_bit("output_rq", seen_rq, 1'b0);
        @(posedge clk);
        scc_enable <= 1'b1;

        level_byte = rand_byte();
        if (level_byte == 8'sd0) begin
            level_byte = 8'sh81;                                // Zero would match silence
        end
        for (int i = 0; i < 32; i++) begin
            mem_write(16'h9800 + 16'(i), level_byte);
        end
        mem_write(16'h9880, 8'h02);                             // One step every 3 cycles
        mem_write(16'h9881, 8'h00);
        mem_write(16'h988A, 8'h0F);
        mem_write(16'h988F, 8'h01);
        exp_sound = {{8{level_byte[7]}}, level_byte};
        exp_sound = exp_sound * 16'sd15;
        wait_sound(exp_sound, "the sound level after key-on");
        repeat (120) begin                                      // Index wraps at least once
            @(negedge clk);
            check_sample("sound", sound, exp_sound);
        end
        mem_write(16'h988F, 8'h00);
        wait_sound(16'sd0, "silence after key-off");

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/devices.sv */
`timescale 1ns/1ps
`default_nettype none

module devices (
    input  wire                     clk,
    input  wire                     rst,
    input  wire msx_bus_pkg::addr_t addr,
    input  wire msx_bus_pkg::data_t wdata,
    input  wire                     rd,
    input  wire                     wr,
    input  wire                     iorq,
    input  wire                     mreq,
    input  wire                     ram_slot_sel,
    input  wire                     cart_slot_sel,
    input  wire                     ram_enable,
    input  wire                     bank_enable,
    input  wire                     scc_enable,
    output msx_bus_pkg::sample_t    sound,
    output msx_bus_pkg::data_t      data,
    output logic                    output_rq,
    output msx_dev_pkg::segment_t   data_to_mapper
);

    msx_bus_pkg::data_t    ram_data;
    logic                  ram_output_rq;
    msx_dev_pkg::segment_t ram_segment;
    msx_dev_pkg::bank_t    cart_bank;
    msx_bus_pkg::data_t    scc_data;
    logic                  scc_output_rq;
    msx_bus_pkg::sample_t  scc_sound;

    mapper_ram_regs i_mapper_ram_regs (
        .clk            (clk),
        .rst            (rst),
        .addr           (addr),
        .wdata          (wdata),
        .rd             (rd),
        .wr             (wr),
        .iorq           (iorq),
        .mreq           (mreq),
        .ram_slot_sel   (ram_slot_sel),
        .ram_enable     (ram_enable),
        .data           (ram_data),
        .output_rq      (ram_output_rq),
        .data_to_mapper (ram_segment)
    );

    bank_mapper i_bank_mapper (
        .clk            (clk),
        .rst            (rst),
        .addr           (addr),
        .wdata          (wdata),
        .wr             (wr),
        .mreq           (mreq),
        .cart_slot_sel  (cart_slot_sel),
        .bank_enable    (bank_enable),
        .data_to_mapper (cart_bank)
    );

    scc_wave i_scc_wave (
        .clk           (clk),
        .rst           (rst),
        .addr          (addr),
        .wdata         (wdata),
        .rd            (rd),
        .wr            (wr),
        .mreq          (mreq),
        .cart_slot_sel (cart_slot_sel),
        .scc_enable    (scc_enable),
        .data          (scc_data),
        .output_rq     (scc_output_rq),
        .sound         (scc_sound)
    );

    // Idle sources drive FF so AND acts as a bus merge
    assign data           = ram_data & scc_data;
    assign output_rq      = ram_output_rq | scc_output_rq;
    assign data_to_mapper = ram_segment & cart_bank;

    // Audio mixer, further sources join this sum
    assign sound = scc_sound;

endmodule

`default_nettype wire

/* rtl/scc_wave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_devices_macros.svh"

module scc_wave (
    input  wire                     clk,
    input  wire                     rst,
    input  wire msx_bus_pkg::addr_t addr,
    input  wire msx_bus_pkg::data_t wdata,
    input  wire                     rd,
    input  wire                     wr,
    input  wire                     mreq,
    input  wire                     cart_slot_sel,
    input  wire                     scc_enable,
    output msx_bus_pkg::data_t      data,
    output logic                    output_rq,
    output msx_bus_pkg::sample_t    sound
);

    localparam msx_bus_pkg::data_t REG_PERIOD_LO = 8'h80;
    localparam msx_bus_pkg::data_t REG_PERIOD_HI = 8'h81;
    localparam msx_bus_pkg::data_t REG_VOLUME    = 8'h8A;
    localparam msx_bus_pkg::data_t REG_KEY_ON    = 8'h8F;

    logic signed [7:0]       wave_ram [32];   // Signed waveform bytes
    msx_dev_pkg::period_t    period_q;
    msx_dev_pkg::volume_t    volume_q;
    msx_dev_pkg::scc_state_t state_q;
    msx_dev_pkg::period_t    div_cnt_q;       // Counts down to the next step
    msx_dev_pkg::wave_idx_t  wave_idx_q;
    logic                    win_sel;
    logic                    wave_sel;
    logic signed [12:0]      level;           // Byte times volume

    assign win_sel  = scc_enable && mreq && cart_slot_sel && (addr[15:8] == `SCC_WINDOW);
    assign wave_sel = win_sel && (addr[7:5] == 3'b000);    // 9800-981F

    always_ff @(posedge clk) begin
        if (wr && wave_sel) begin
            wave_ram[addr[4:0]] <= wdata;
        end
    end

    // Channel registers, key-on drives the playback state
    always_ff @(posedge clk) begin
        if (rst) begin
            period_q <= '0;
            volume_q <= '0;
            state_q  <= msx_dev_pkg::scc_idle;
        end else if (wr && win_sel) begin
            case (addr[7:0])
                REG_PERIOD_LO: period_q[7:0]  <= wdata;
                REG_PERIOD_HI: period_q[11:8] <= wdata[3:0];
                REG_VOLUME:    volume_q       <= wdata[3:0];
                REG_KEY_ON: begin
                    if (wdata[0]) begin
                        state_q <= msx_dev_pkg::scc_play;
                    end else begin
                        state_q <= msx_dev_pkg::scc_idle;
                    end
                end
                default: ;
            endcase
        end
    end

    // Tone divider, one wave step per expiry
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt_q  <= '0;
            wave_idx_q <= '0;
        end else if (state_q == msx_dev_pkg::scc_idle) begin
            div_cnt_q  <= period_q;                // Restart from the first byte
            wave_idx_q <= '0;
        end else if (div_cnt_q == '0) begin
            div_cnt_q  <= period_q;
            wave_idx_q <= wave_idx_q + 1'b1;       // Wraps after 32 bytes
        end else begin
            div_cnt_q <= div_cnt_q - 1'b1;
        end
    end

    assign level = wave_ram[wave_idx_q] * $signed({1'b0, volume_q});

    always_ff @(posedge clk) begin
        if (rst) begin
            sound <= '0;
        end else if (state_q == msx_dev_pkg::scc_play) begin
            sound <= msx_bus_pkg::sample_t'(level);   // Sign-extended
        end else begin
            sound <= '0;
        end
    end

    // Only wave RAM is readable
    assign output_rq = rd && wave_sel;
    assign data      = output_rq ? msx_bus_pkg::data_t'(wave_ram[addr[4:0]]) : 8'hFF;

endmodule

`default_nettype wire

/* rtl/bank_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_devices_macros.svh"

module bank_mapper (
    input  wire                     clk,
    input  wire                     rst,
    input  wire msx_bus_pkg::addr_t addr,
    input  wire msx_bus_pkg::data_t wdata,
    input  wire                     wr,
    input  wire                     mreq,
    input  wire                     cart_slot_sel,
    input  wire                     bank_enable,
    output msx_dev_pkg::bank_t      data_to_mapper
);

    localparam msx_bus_pkg::addr_t BANK_BASE = `BANK_REG_BASE;
    localparam msx_bus_pkg::addr_t WIN_BASE  = 16'h4000;

    msx_dev_pkg::bank_t bank_q [4];    // 8 KB banks over 4000-BFFF
    msx_bus_pkg::addr_t win_offset;
    logic               cart_sel;
    logic               reg_hit;
    logic               in_window;

    assign cart_sel = bank_enable && mreq && cart_slot_sel;

    // 6000-7FFF, one register per 2 KB step
    assign reg_hit = (addr[15:13] == BANK_BASE[15:13]);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                bank_q[i] <= msx_dev_pkg::bank_t'(i);
            end
        end else if (wr && cart_sel && reg_hit) begin
            bank_q[addr[12:11]] <= wdata;
        end
    end

    assign in_window  = (addr[15:14] == 2'b01) || (addr[15:14] == 2'b10);
    assign win_offset = addr - WIN_BASE;

    // Bits [14:13] of the offset pick the 8 KB page
    assign data_to_mapper = (cart_sel && in_window) ? bank_q[win_offset[14:13]] : 8'hFF;

endmodule

`default_nettype wire

/* rtl/mapper_ram_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "msx_devices_macros.svh"

module mapper_ram_regs (
    input  wire                     clk,
    input  wire                     rst,
    input  wire msx_bus_pkg::addr_t addr,
    input  wire msx_bus_pkg::data_t wdata,
    input  wire                     rd,
    input  wire                     wr,
    input  wire                     iorq,
    input  wire                     mreq,
    input  wire                     ram_slot_sel,
    input  wire                     ram_enable,
    output msx_bus_pkg::data_t      data,
    output logic                    output_rq,
    output msx_dev_pkg::segment_t   data_to_mapper
);

    localparam int SEG_BITS  = `MAPPER_SEG_BITS;
    localparam int FILL_BITS = 8 - SEG_BITS;
    localparam msx_bus_pkg::data_t PORT_BASE = `MAPPER_PORT_BASE;

    logic [SEG_BITS-1:0] seg_q [4];    // One segment per 16 KB page
    logic                port_hit;
    logic                io_sel;
    logic                mem_sel;

    // Unstored upper bits read back as ones
    function automatic msx_dev_pkg::segment_t seg_fill(input logic [SEG_BITS-1:0] seg);
        return {{FILL_BITS{1'b1}}, seg};
    endfunction

    assign port_hit = (addr[7:2] == PORT_BASE[7:2]);       // Ports FC to FF
    assign io_sel   = ram_enable && iorq && port_hit;
    assign mem_sel  = ram_enable && mreq && ram_slot_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                seg_q[i] <= SEG_BITS'(3 - i);              // Pages 0..3 get 3..0
            end
        end else if (wr && io_sel) begin
            seg_q[addr[1:0]] <= wdata[SEG_BITS-1:0];
        end
    end

    // I/O readback of the addressed port
    assign output_rq = rd && io_sel;
    assign data      = output_rq ? seg_fill(seg_q[addr[1:0]]) : 8'hFF;

    // Segment for the page the CPU is touching
    assign data_to_mapper = mem_sel ? seg_fill(seg_q[addr[15:14]]) : 8'hFF;

endmodule

`default_nettype wire

/* rtl/msx_dev_pkg.sv */
`default_nettype none

package msx_dev_pkg;

    // Segment as presented to the slot mapper
    typedef logic [7:0] segment_t;

    // 8 KB cartridge bank number
    typedef logic [7:0] bank_t;

    // Position in the 32-byte wave RAM
    typedef logic [4:0] wave_idx_t;

    // Tone divider reload value
    typedef logic [11:0] period_t;

    // Channel attenuation, 15 is loudest
    typedef logic [3:0] volume_t;

    typedef enum logic {
        scc_idle,   // Channel silent
        scc_play    // Channel stepping through wave RAM
    } scc_state_t;

endpackage

`default_nettype wire

/* rtl/msx_bus_pkg.sv */
`default_nettype none

package msx_bus_pkg;

    // Z80 address bus
    typedef logic [15:0] addr_t;

    // Z80 data byte, also used for merged read data
    typedef logic [7:0] data_t;

    // Audio sample, two's complement
    typedef logic signed [15:0] sample_t;

endpackage

`default_nettype wire

/* include/msx_devices_macros.svh */
`ifndef MSX_DEVICES_MACROS_SVH
`define MSX_DEVICES_MACROS_SVH

// First of the four memory-mapper I/O ports, FC to FF
`define MAPPER_PORT_BASE 8'hFC

// Stored segment bits, 8 segments of 16 KB
`define MAPPER_SEG_BITS 3

// Bank register 0 of the cartridge mapper
// Registers 1 to 3 follow at 6800, 7000 and 7800
`define BANK_REG_BASE 16'h6000

// High address byte of the SCC register window
`define SCC_WINDOW 8'h98

`endif
